// ==== ctrl_cfg.svh ====
// Build-time configuration of the control board
// Channel count, local bus address map fields,
// reset baud divisor and version byte

`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// **************************************************
// Channel array
// **************************************************
`define UART_NUMS       4       // At most 8

// **************************************************
// Local bus
// **************************************************
`define LBS_ADDR_W      8
`define LBS_DATA_W      8

// Upper four address bits pick the region
`define LBS_REGION_SYS  15

// **************************************************
// Reset values
// **************************************************
`define BAUD_DIV_RST    16      // Clocks per bit
`define CTRL_VERSION    8'hA5

`endif

// ==== ctrl_pkg.sv ====
// Shared types of the control board
// Bus address and data, channel mask,
// register offset enums and UART FSM states

`include "ctrl_cfg.svh"

package ctrl_pkg;

    typedef logic [`LBS_ADDR_W-1:0] lbs_addr_t;
    typedef logic [`LBS_DATA_W-1:0] lbs_data_t;
    typedef logic [`UART_NUMS-1:0]  uart_mask_t;   // One bit per channel

    // **************************************************
    // Register offsets, address bits 1:0
    // **************************************************
    typedef enum logic [1:0]
    {
        UART_DATA    = 2'd0,    // Wr loads tx, rd returns rx byte
        UART_STATUS  = 2'd1,    // Tx busy, rx valid, rx overrun
        UART_BAUD_LO = 2'd2,
        UART_BAUD_HI = 2'd3
    } uart_reg_e;

    typedef enum logic [1:0]
    {
        SYS_INT_MASK   = 2'd0,
        SYS_INT_STATUS = 2'd1,  // Read only
        SYS_SOFT_RST   = 2'd2,
        SYS_VERSION    = 2'd3   // Read only
    } sys_reg_e;

    // **************************************************
    // UART state machines
    // **************************************************
    typedef enum logic [1:0]
    {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_e;

    typedef enum logic [1:0]
    {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } rx_state_e;

endpackage

// ==== lbs_decoder.sv ====
// Local bus decoder
// Strobe qualification, region decode into
// channel and system selects, registered read data

`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module lbs_decoder
(
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  lbs_cs_n_i,
    input  logic                                  lbs_we_i,
    input  logic                                  lbs_re_i,
    input  ctrl_pkg::lbs_addr_t                   lbs_addr_i,
    input  ctrl_pkg::lbs_data_t                   lbs_wdata_i,
    output ctrl_pkg::lbs_data_t                   lbs_rdata_o,
    output logic [1:0]                            reg_addr_o,
    output ctrl_pkg::lbs_data_t                   reg_wdata_o,
    output logic                                  reg_we_o,
    output logic                                  reg_re_o,
    output ctrl_pkg::uart_mask_t                  chan_sel_o,
    output logic                                  sys_sel_o,
    input  ctrl_pkg::lbs_data_t [`UART_NUMS-1:0]  chan_rdata_i,
    input  ctrl_pkg::lbs_data_t                   sys_rdata_i
);

logic [3:0]           region;
ctrl_pkg::lbs_data_t  rd_mux;

// **************************************************
// Strobes and selects
// **************************************************
assign region      = lbs_addr_i[`LBS_ADDR_W-1 -: 4];
assign reg_addr_o  = lbs_addr_i[1:0];               // Bits 3:2 ignored
assign reg_wdata_o = lbs_wdata_i;
assign reg_we_o    = ~lbs_cs_n_i & lbs_we_i;
assign reg_re_o    = ~lbs_cs_n_i & lbs_re_i;
assign sys_sel_o   = ~lbs_cs_n_i & (region == 4'(`LBS_REGION_SYS));

always_comb
begin
    for (int i = 0; i < `UART_NUMS; i++)
        chan_sel_o[i] = ~lbs_cs_n_i & (region == 4'(i));
end

// Unused regions fall through as zero
always_comb
begin
    rd_mux = '0;
    if (sys_sel_o)
        rd_mux = sys_rdata_i;
    for (int i = 0; i < `UART_NUMS; i++)
    begin
        if (chan_sel_o[i])
            rd_mux = chan_rdata_i[i];
    end
end

// **************************************************
// Read data register
// **************************************************
always_ff @(posedge clk_i)
begin
    if (!rst_n_i)
        lbs_rdata_o <= '0;
    else if (reg_re_o)
        lbs_rdata_o <= rd_mux;              // Held until next read
end

endmodule

// ==== uart_channel.sv ====
// One UART channel, 8N1
// Baud divisor and bit counter, transmitter,
// receiver with status flags, interrupt

`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module uart_channel
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 soft_rst_i,
    input  logic                 sel_i,
    input  logic                 we_i,
    input  logic                 re_i,
    input  logic [1:0]           addr_i,
    input  ctrl_pkg::lbs_data_t  wdata_i,
    output ctrl_pkg::lbs_data_t  rdata_o,
    input  logic                 rx_i,
    output logic                 tx_o,
    output logic                 irq_o
);

logic                 chan_rst;
logic                 wr_data;
logic                 wr_baud_lo;
logic                 wr_baud_hi;
logic                 rd_data;
logic [15:0]          baud_div;
logic [15:0]          baud_cnt;
logic                 baud_tick;
ctrl_pkg::tx_state_e  tx_state;
logic                 tx_pend;
logic [7:0]           tx_shift;
logic [2:0]           tx_bit_cnt;
logic                 tx_busy;
logic [2:0]           rx_sync;
logic                 rx_fall;
ctrl_pkg::rx_state_e  rx_state;
logic [15:0]          rx_cnt;
logic                 rx_half;
logic                 rx_full;
logic [2:0]           rx_bit_cnt;
logic [7:0]           rx_shift;
logic                 rx_done;
ctrl_pkg::lbs_data_t  rx_data;
logic                 rx_valid;
logic                 rx_ovr;

assign chan_rst   = ~rst_n_i | soft_rst_i;
assign wr_data    = sel_i & we_i & (addr_i == ctrl_pkg::UART_DATA);
assign wr_baud_lo = sel_i & we_i & (addr_i == ctrl_pkg::UART_BAUD_LO);
assign wr_baud_hi = sel_i & we_i & (addr_i == ctrl_pkg::UART_BAUD_HI);
assign rd_data    = sel_i & re_i & (addr_i == ctrl_pkg::UART_DATA);

// **************************************************
// Baud divisor and bit-period counter
// **************************************************
always_ff @(posedge clk_i)
begin
    if (chan_rst)
        baud_div <= 16'(`BAUD_DIV_RST);
    else
    begin
        if (wr_baud_lo)
            baud_div[7:0] <= wdata_i;
        if (wr_baud_hi)
            baud_div[15:8] <= wdata_i;
    end
end

assign baud_tick = (baud_cnt >= baud_div - 16'd1);

always_ff @(posedge clk_i)
begin
    if (chan_rst || baud_tick)
        baud_cnt <= '0;
    else
        baud_cnt <= baud_cnt + 16'd1;
end

// **************************************************
// Transmitter
// **************************************************
assign tx_busy = tx_pend | (tx_state != ctrl_pkg::TX_IDLE);

always_ff @(posedge clk_i)
begin
    if (wr_data && !tx_busy)
        tx_shift <= wdata_i;
    else if (baud_tick && tx_state == ctrl_pkg::TX_DATA)
        tx_shift <= {1'b0, tx_shift[7:1]};       // LSB first
end

always_ff @(posedge clk_i)
begin
    if (chan_rst)
    begin
        tx_state   <= ctrl_pkg::TX_IDLE;
        tx_pend    <= 1'b0;
        tx_bit_cnt <= '0;
        tx_o       <= 1'b1;
    end
    else
    begin
        if (wr_data && !tx_busy)
            tx_pend <= 1'b1;                     // Write while busy is dropped
        if (baud_tick)
        begin
            case (tx_state)
                ctrl_pkg::TX_IDLE:
                    if (tx_pend)
                    begin
                        tx_pend  <= 1'b0;
                        tx_o     <= 1'b0;        // Start bit
                        tx_state <= ctrl_pkg::TX_START;
                    end
                ctrl_pkg::TX_START:
                begin
                    tx_o       <= tx_shift[0];
                    tx_bit_cnt <= '0;
                    tx_state   <= ctrl_pkg::TX_DATA;
                end
                ctrl_pkg::TX_DATA:
                begin
                    tx_bit_cnt <= tx_bit_cnt + 3'd1;
                    if (tx_bit_cnt == 3'd7)
                    begin
                        tx_o     <= 1'b1;        // Stop bit
                        tx_state <= ctrl_pkg::TX_STOP;
                    end
                    else
                        tx_o <= tx_shift[1];
                end
                default:
                    tx_state <= ctrl_pkg::TX_IDLE;
            endcase
        end
    end
end

// **************************************************
// Receiver
// **************************************************
always_ff @(posedge clk_i)
begin
    if (chan_rst)
        rx_sync <= 3'b111;
    else
        rx_sync <= {rx_sync[1:0], rx_i};
end

assign rx_fall = rx_sync[2] & ~rx_sync[1];
assign rx_half = (rx_cnt >= {1'b0, baud_div[15:1]} - 16'd1);
assign rx_full = (rx_cnt >= baud_div - 16'd1);
assign rx_done = (rx_state == ctrl_pkg::RX_STOP) & rx_full & rx_sync[1];

always_ff @(posedge clk_i)
begin
    if (chan_rst)
    begin
        rx_state   <= ctrl_pkg::RX_IDLE;
        rx_cnt     <= '0;
        rx_bit_cnt <= '0;
    end
    else
    begin
        case (rx_state)
            ctrl_pkg::RX_IDLE:
            begin
                rx_cnt <= '0;
                if (rx_fall)
                    rx_state <= ctrl_pkg::RX_START;
            end
            ctrl_pkg::RX_START:
                if (rx_half)                     // Mid start bit, still low?
                begin
                    rx_cnt     <= '0;
                    rx_bit_cnt <= '0;
                    rx_state   <= rx_sync[1] ? ctrl_pkg::RX_IDLE : ctrl_pkg::RX_DATA;
                end
                else
                    rx_cnt <= rx_cnt + 16'd1;
            ctrl_pkg::RX_DATA:
                if (rx_full)
                begin
                    rx_cnt     <= '0;
                    rx_bit_cnt <= rx_bit_cnt + 3'd1;
                    if (rx_bit_cnt == 3'd7)
                        rx_state <= ctrl_pkg::RX_STOP;
                end
                else
                    rx_cnt <= rx_cnt + 16'd1;
            default:
                if (rx_full)
                begin
                    rx_cnt   <= '0;
                    rx_state <= ctrl_pkg::RX_IDLE;   // Low stop bit dropped
                end
                else
                    rx_cnt <= rx_cnt + 16'd1;
        endcase
    end
end

always_ff @(posedge clk_i)
begin
    if (rx_state == ctrl_pkg::RX_DATA && rx_full)
        rx_shift <= {rx_sync[1], rx_shift[7:1]};
end

// New byte wins over a read in the same cycle
always_ff @(posedge clk_i)
begin
    if (chan_rst)
    begin
        rx_data  <= '0;
        rx_valid <= 1'b0;
        rx_ovr   <= 1'b0;
    end
    else if (rx_done)
    begin
        rx_data  <= rx_shift;
        rx_valid <= 1'b1;
        if (rx_valid && !rd_data)
            rx_ovr <= 1'b1;
        else if (rd_data)
            rx_ovr <= 1'b0;
    end
    else if (rd_data)
    begin
        rx_valid <= 1'b0;
        rx_ovr   <= 1'b0;
    end
end

assign irq_o = rx_valid;

// **************************************************
// Register read
// **************************************************
always_comb
begin
    case (ctrl_pkg::uart_reg_e'(addr_i))
        ctrl_pkg::UART_DATA:    rdata_o = rx_data;
        ctrl_pkg::UART_STATUS:  rdata_o = {5'd0, rx_ovr, rx_valid, tx_busy};
        ctrl_pkg::UART_BAUD_LO: rdata_o = baud_div[7:0];
        default:                rdata_o = baud_div[15:8];
    endcase
end

endmodule

// ==== sys_registers.sv ====
// System register block
// Interrupt mask, raw interrupt status, per-channel
// soft resets, version byte, combined interrupt

`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module sys_registers
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  sel_i,
    input  logic                  we_i,
    input  logic [1:0]            addr_i,
    input  ctrl_pkg::lbs_data_t   wdata_i,
    output ctrl_pkg::lbs_data_t   rdata_o,
    input  ctrl_pkg::uart_mask_t  chan_irq_i,
    output ctrl_pkg::uart_mask_t  soft_rst_o,
    output logic                  int_o
);

ctrl_pkg::uart_mask_t  int_mask;
logic                  wr_mask;
logic                  wr_soft_rst;

assign wr_mask     = sel_i & we_i & (addr_i == ctrl_pkg::SYS_INT_MASK);
assign wr_soft_rst = sel_i & we_i & (addr_i == ctrl_pkg::SYS_SOFT_RST);

// **************************************************
// Writable registers
// **************************************************
always_ff @(posedge clk_i)
begin
    if (!rst_n_i)
    begin
        int_mask   <= '0;
        soft_rst_o <= '0;
    end
    else
    begin
        if (wr_mask)
            int_mask <= wdata_i[`UART_NUMS-1:0];
        if (wr_soft_rst)
            soft_rst_o <= wdata_i[`UART_NUMS-1:0];   // Level, held until cleared
    end
end

// Combined interrupt, one cycle behind the sources
always_ff @(posedge clk_i)
begin
    if (!rst_n_i)
        int_o <= 1'b0;
    else
        int_o <= |(chan_irq_i & int_mask);
end

// **************************************************
// Register read
// **************************************************
always_comb
begin
    rdata_o = '0;
    case (ctrl_pkg::sys_reg_e'(addr_i))
        ctrl_pkg::SYS_INT_MASK:
            rdata_o[`UART_NUMS-1:0] = int_mask;
        ctrl_pkg::SYS_INT_STATUS:
            rdata_o[`UART_NUMS-1:0] = chan_irq_i;    // Raw, unmasked
        ctrl_pkg::SYS_SOFT_RST:
            rdata_o[`UART_NUMS-1:0] = soft_rst_o;
        default:
            rdata_o = `CTRL_VERSION;
    endcase
end

endmodule

// ==== control_board.sv ====
// Control board top level
// Local bus decoder, UART channel array,
// system registers

`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module control_board
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  lbs_cs_n_i,
    input  logic                  lbs_we_i,
    input  logic                  lbs_re_i,
    input  ctrl_pkg::lbs_addr_t   lbs_addr_i,
    input  ctrl_pkg::lbs_data_t   lbs_wdata_i,
    output ctrl_pkg::lbs_data_t   lbs_rdata_o,
    input  ctrl_pkg::uart_mask_t  uart_rx_i,
    output ctrl_pkg::uart_mask_t  uart_tx_o,
    output logic                  int_o
);

logic [1:0]                            reg_addr;
ctrl_pkg::lbs_data_t                   reg_wdata;
logic                                  reg_we;
logic                                  reg_re;
ctrl_pkg::uart_mask_t                  chan_sel;
logic                                  sys_sel;
ctrl_pkg::lbs_data_t [`UART_NUMS-1:0]  chan_rdata;
ctrl_pkg::lbs_data_t                   sys_rdata;
ctrl_pkg::uart_mask_t                  chan_irq;
ctrl_pkg::uart_mask_t                  soft_rst;

lbs_decoder u_lbs_decoder
(
    .clk_i          (clk_i          ),
    .rst_n_i        (rst_n_i        ),
    .lbs_cs_n_i     (lbs_cs_n_i     ),
    .lbs_we_i       (lbs_we_i       ),
    .lbs_re_i       (lbs_re_i       ),
    .lbs_addr_i     (lbs_addr_i     ),
    .lbs_wdata_i    (lbs_wdata_i    ),
    .lbs_rdata_o    (lbs_rdata_o    ),
    .reg_addr_o     (reg_addr       ),
    .reg_wdata_o    (reg_wdata      ),
    .reg_we_o       (reg_we         ),
    .reg_re_o       (reg_re         ),
    .chan_sel_o     (chan_sel       ),
    .sys_sel_o      (sys_sel        ),
    .chan_rdata_i   (chan_rdata     ),
    .sys_rdata_i    (sys_rdata      )
);

// **************************************************
// UART channel array
// **************************************************
genvar i;
generate
    for (i = 0; i < `UART_NUMS; i = i + 1)
    begin : gen_chan
        uart_channel u_uart_channel
        (
            .clk_i      (clk_i          ),
            .rst_n_i    (rst_n_i        ),
            .soft_rst_i (soft_rst[i]    ),
            .sel_i      (chan_sel[i]    ),
            .we_i       (reg_we         ),
            .re_i       (reg_re         ),
            .addr_i     (reg_addr       ),
            .wdata_i    (reg_wdata      ),
            .rdata_o    (chan_rdata[i]  ),
            .rx_i       (uart_rx_i[i]   ),
            .tx_o       (uart_tx_o[i]   ),
            .irq_o      (chan_irq[i]    )
        );
    end
endgenerate

sys_registers u_sys_registers
(
    .clk_i          (clk_i          ),
    .rst_n_i        (rst_n_i        ),
    .sel_i          (sys_sel        ),
    .we_i           (reg_we         ),
    .addr_i         (reg_addr       ),
    .wdata_i        (reg_wdata      ),
    .rdata_o        (sys_rdata      ),
    .chan_irq_i     (chan_irq       ),
    .soft_rst_o     (soft_rst       ),
    .int_o          (int_o          )
);

endmodule

// ==== control_board_assert.sv ====
// Concurrent checks on the control board
// Strobe exclusivity, masked interrupt,
// tx line during soft reset, bind to the top level

`timescale 1ns/1ps

module control_board_assert
(
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  lbs_cs_n_i,
    input logic                  lbs_we_i,
    input logic                  lbs_re_i,
    input ctrl_pkg::uart_mask_t  int_mask_i,
    input ctrl_pkg::uart_mask_t  soft_rst_i,
    input ctrl_pkg::uart_mask_t  uart_tx_i,
    input logic                  int_i
);

int fail_cnt = 0;           // Failed assertions so far

a_strobe_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !lbs_cs_n_i |-> !(lbs_we_i && lbs_re_i))
    else
    begin
        fail_cnt++;
        $error("write and read strobes both high under chip select");
    end

// Registered OR lags the mask by one cycle
a_int_masked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (int_mask_i == '0) && $past(int_mask_i == '0) |-> !int_i)
    else
    begin
        fail_cnt++;
        $error("interrupt high while mask is zero");
    end

a_tx_soft_rst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(soft_rst_i) & ~uart_tx_i) == '0)
    else
    begin
        fail_cnt++;
        $error("tx line low while channel held in soft reset");
    end

endmodule

bind control_board control_board_assert u_control_board_assert
(
    .clk_i      (clk_i                     ),
    .rst_n_i    (rst_n_i                   ),
    .lbs_cs_n_i (lbs_cs_n_i                ),
    .lbs_we_i   (lbs_we_i                  ),
    .lbs_re_i   (lbs_re_i                  ),
    .int_mask_i (u_sys_registers.int_mask  ),
    .soft_rst_i (soft_rst                  ),
    .uart_tx_i  (uart_tx_o                 ),
    .int_i      (int_o                     )
);

// ==== tb_control_board.sv ====
// Testbench for the control board
// Clock and reset, local bus tasks, serial loopback,
// register model with expected values, comparing
// process and cycle-limit timeout

`timescale 1ns/1ps
`include "ctrl_cfg.svh"

module tb_control_board;

localparam int         DIV_MAX    = 40;     // Largest divisor used in traffic
localparam int         CYC_LIMIT  = 4 * `UART_NUMS * 12 * 10 * DIV_MAX + 2000;
localparam logic [3:0] SYS_REGION = 4'(`LBS_REGION_SYS);

logic                  clk;
logic                  rst_n;
logic                  cs_n;
logic                  we;
logic                  re;
ctrl_pkg::lbs_addr_t   addr;
ctrl_pkg::lbs_data_t   wdata;
ctrl_pkg::lbs_data_t   rdata;
ctrl_pkg::uart_mask_t  serial;              // Tx looped back to rx
logic                  int_irq;

integer                seed   = 24979;
int                    errors = 0;
int                    checks = 0;
int                    cycles = 0;

// **************************************************
// Register model
// **************************************************
logic [15:0]           m_baud    [`UART_NUMS];
ctrl_pkg::lbs_data_t   m_rx_data [`UART_NUMS];
ctrl_pkg::lbs_data_t   m_tx_byte [`UART_NUMS];
ctrl_pkg::uart_mask_t  m_valid;
ctrl_pkg::uart_mask_t  m_ovr;
ctrl_pkg::uart_mask_t  m_busy;
ctrl_pkg::uart_mask_t  m_mask;
ctrl_pkg::uart_mask_t  m_srst;

ctrl_pkg::lbs_data_t   act_q [$];
ctrl_pkg::lbs_data_t   exp_q [$];
string                 msg_q [$];

control_board uut
(
    .clk_i       (clk     ),
    .rst_n_i     (rst_n   ),
    .lbs_cs_n_i  (cs_n    ),
    .lbs_we_i    (we      ),
    .lbs_re_i    (re      ),
    .lbs_addr_i  (addr    ),
    .lbs_wdata_i (wdata   ),
    .lbs_rdata_o (rdata   ),
    .uart_rx_i   (serial  ),
    .uart_tx_o   (serial  ),
    .int_o       (int_irq )
);

initial
begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

function automatic ctrl_pkg::lbs_addr_t chan_addr(input int ch, input logic [1:0] off);
    return {4'(ch), 2'b00, off};
endfunction

function automatic ctrl_pkg::lbs_addr_t sys_addr(input logic [1:0] off);
    return {SYS_REGION, 2'b00, off};
endfunction

function automatic ctrl_pkg::lbs_data_t expected_read(input ctrl_pkg::lbs_addr_t a);
    logic [3:0] region;
    logic [1:0] off;
    int         ch;
    region = a[7:4];
    off    = a[1:0];
    ch     = int'(region);
    expected_read = '0;                     // Unused regions
    if (region == SYS_REGION)
    begin
        case (off)
            2'd0:    expected_read = 8'(m_mask);
            2'd1:    expected_read = 8'(m_valid);   // Raw, unmasked
            2'd2:    expected_read = 8'(m_srst);
            default: expected_read = 8'(`CTRL_VERSION);
        endcase
    end
    else if (ch < `UART_NUMS)
    begin
        case (off)
            2'd0:    expected_read = m_rx_data[ch];
            2'd1:    expected_read = {5'd0, m_ovr[ch], m_valid[ch], m_busy[ch]};
            2'd2:    expected_read = m_baud[ch][7:0];
            default: expected_read = m_baud[ch][15:8];
        endcase
    end
endfunction

function automatic logic expected_int();
    return |(m_valid & m_mask);
endfunction

task automatic model_chan_reset(input int ch);
    m_baud[ch]    = 16'(`BAUD_DIV_RST);
    m_rx_data[ch] = '0;
    m_valid[ch]   = 1'b0;
    m_ovr[ch]     = 1'b0;
    m_busy[ch]    = 1'b0;
endtask

task automatic model_write(input ctrl_pkg::lbs_addr_t a, input ctrl_pkg::lbs_data_t d);
    int ch;
    ch = int'(a[7:4]);
    if (a[7:4] == SYS_REGION)
    begin
        if (a[1:0] == 2'd0)
            m_mask = d[`UART_NUMS-1:0];
        else if (a[1:0] == 2'd2)
        begin
            m_srst = d[`UART_NUMS-1:0];
            for (int i = 0; i < `UART_NUMS; i++)
                if (m_srst[i])
                    model_chan_reset(i);
        end
    end
    else if (ch < `UART_NUMS && !m_srst[ch])
    begin
        if (a[1:0] == 2'd0 && !m_busy[ch])  // Busy transmitter drops the byte
        begin
            m_busy[ch]    = 1'b1;
            m_tx_byte[ch] = d;
        end
        else if (a[1:0] == 2'd2)
            m_baud[ch][7:0] = d;
        else if (a[1:0] == 2'd3)
            m_baud[ch][15:8] = d;
    end
endtask

task automatic model_read(input ctrl_pkg::lbs_addr_t a);
    int ch;
    ch = int'(a[7:4]);
    if (a[7:4] != SYS_REGION && ch < `UART_NUMS && !m_srst[ch] && a[1:0] == 2'd0)
    begin
        m_valid[ch] = 1'b0;
        m_ovr[ch]   = 1'b0;
    end
endtask

// Frame seen at the receiver
task automatic note_rx(input int ch);
    if (m_valid[ch])
        m_ovr[ch] = 1'b1;
    m_valid[ch]   = 1'b1;
    m_rx_data[ch] = m_tx_byte[ch];
endtask

// **************************************************
// Bus access and checks
// **************************************************
task automatic check(input ctrl_pkg::lbs_data_t act, input ctrl_pkg::lbs_data_t exp_val,
                     input string msg);
    checks++;
    if (act !== exp_val)
    begin
        errors++;
        $display("[FAIL] %0t ns: %s, got %02h expected %02h", $time, msg, act, exp_val);
    end
endtask

task automatic bus_write(input ctrl_pkg::lbs_addr_t a, input ctrl_pkg::lbs_data_t d);
    @(negedge clk);
    cs_n  = 1'b0;
    we    = 1'b1;
    addr  = a;
    wdata = d;
    @(negedge clk);
    cs_n  = 1'b1;
    we    = 1'b0;
    model_write(a, d);
endtask

task automatic bus_read(input ctrl_pkg::lbs_addr_t a, output ctrl_pkg::lbs_data_t d);
    @(negedge clk);
    cs_n = 1'b0;
    re   = 1'b1;
    addr = a;
    @(negedge clk);
    cs_n = 1'b1;
    re   = 1'b0;
    d    = rdata;                           // Registered at the strobe edge
endtask

task automatic read_check(input ctrl_pkg::lbs_addr_t a, input string msg);
    ctrl_pkg::lbs_data_t exp_val;
    ctrl_pkg::lbs_data_t act;
    exp_val = expected_read(a);
    bus_read(a, act);
    act_q.push_back(act);
    exp_q.push_back(exp_val);
    msg_q.push_back(msg);
    model_read(a);
endtask

task automatic wait_status(input int ch, input int bit_n, input logic level);
    ctrl_pkg::lbs_data_t st;
    do
        bus_read(chan_addr(ch, ctrl_pkg::UART_STATUS), st);
    while (st[bit_n] !== level);
endtask

// Loopback frame, then wait for tx idle
task automatic transfer(input int ch, input ctrl_pkg::lbs_data_t b, input int flag_bit);
    bus_write(chan_addr(ch, ctrl_pkg::UART_DATA), b);
    wait_status(ch, flag_bit, 1'b1);
    note_rx(ch);
    wait_status(ch, 0, 1'b0);
    m_busy[ch] = 1'b0;
endtask

task automatic idle(input int n);
    repeat (n) @(negedge clk);
endtask

// Comparing process
initial
begin
    forever
    begin
        @(posedge clk);
        while (act_q.size() > 0)
            check(act_q.pop_front(), exp_q.pop_front(), msg_q.pop_front());
    end
end

initial
begin
    while (cycles < CYC_LIMIT)
    begin
        @(posedge clk);
        cycles = cycles + 1;
    end
    $display("Timeout: run stopped after %0d cycles", cycles);
    $display("Simulation failed");
    $finish;
end

// **************************************************
// Stimulus
// **************************************************
initial
begin
    ctrl_pkg::lbs_data_t b;
    ctrl_pkg::lbs_data_t b2;
    logic [15:0]         div;
    int                  k;
    rst_n  = 1'b0;
    cs_n   = 1'b1;
    we     = 1'b0;
    re     = 1'b0;
    addr   = '0;
    wdata  = '0;
    m_mask = '0;
    m_srst = '0;
    k      = `UART_NUMS - 1;
    for (int i = 0; i < `UART_NUMS; i++)
        model_chan_reset(i);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Reset values
    for (int ch = 0; ch < `UART_NUMS; ch++)
        for (int off = 0; off < 4; off++)
            read_check(chan_addr(ch, 2'(off)), $sformatf("chan %0d reg %0d reset", ch, off));
    for (int off = 0; off < 4; off++)
        read_check(sys_addr(2'(off)), $sformatf("sys reg %0d reset", off));
    check({7'd0, int_irq}, 8'd0, "int_o after reset");
    check(8'(serial), 8'({`UART_NUMS{1'b1}}), "tx lines after reset");

    // Readback and unused regions
    for (int ch = 0; ch < `UART_NUMS; ch++)
    begin
        bus_write(chan_addr(ch, ctrl_pkg::UART_BAUD_LO), 8'($random(seed)));
        bus_write(chan_addr(ch, ctrl_pkg::UART_BAUD_HI), 8'($random(seed)));
        read_check(chan_addr(ch, ctrl_pkg::UART_BAUD_LO), $sformatf("chan %0d baud lo", ch));
        read_check(chan_addr(ch, ctrl_pkg::UART_BAUD_HI), $sformatf("chan %0d baud hi", ch));
    end
    bus_write(sys_addr(ctrl_pkg::SYS_INT_MASK), 8'($random(seed)));
    read_check(sys_addr(ctrl_pkg::SYS_INT_MASK) | 8'h0C, "mask through bits 3:2");
    bus_write(sys_addr(ctrl_pkg::SYS_INT_MASK), 8'h00);
    bus_write(sys_addr(ctrl_pkg::SYS_SOFT_RST), 8'($random(seed)));
    read_check(sys_addr(ctrl_pkg::SYS_SOFT_RST), "soft reset readback");
    bus_write(sys_addr(ctrl_pkg::SYS_SOFT_RST), 8'h00);
    read_check(chan_addr(0, ctrl_pkg::UART_BAUD_LO), "chan 0 baud after soft reset");
    for (int r = `UART_NUMS; r < 15; r++)
    begin
        bus_write({4'(r), 4'h0}, 8'hFF);    // Ignored
        read_check({4'(r), 2'b00, 2'(r)}, $sformatf("unused region %0d", r));
    end

    // Loopback per channel
    for (int ch = 0; ch < `UART_NUMS; ch++)
    begin
        div = 16'(8 + ($random(seed) & 31));
        bus_write(chan_addr(ch, ctrl_pkg::UART_BAUD_LO), div[7:0]);
        bus_write(chan_addr(ch, ctrl_pkg::UART_BAUD_HI), div[15:8]);
        transfer(ch, 8'($random(seed)), 1);
        read_check(chan_addr(ch, ctrl_pkg::UART_STATUS), $sformatf("chan %0d rx valid", ch));
        read_check(chan_addr(ch, ctrl_pkg::UART_DATA), $sformatf("chan %0d rx byte", ch));
        read_check(chan_addr(ch, ctrl_pkg::UART_STATUS), $sformatf("chan %0d cleared", ch));
    end

    // Busy write dropped, then overrun
    b  = 8'($random(seed));
    b2 = ~b;
    bus_write(chan_addr(0, ctrl_pkg::UART_DATA), b);
    bus_write(chan_addr(0, ctrl_pkg::UART_DATA), b2);
    wait_status(0, 1, 1'b1);
    note_rx(0);
    wait_status(0, 0, 1'b0);
    m_busy[0] = 1'b0;
    read_check(chan_addr(0, ctrl_pkg::UART_DATA), "first byte only");
    read_check(chan_addr(0, ctrl_pkg::UART_STATUS), "no second frame");
    transfer(0, b, 1);
    transfer(0, b2, 2);
    read_check(chan_addr(0, ctrl_pkg::UART_STATUS), "overrun status");
    read_check(chan_addr(0, ctrl_pkg::UART_DATA), "second byte kept");
    read_check(chan_addr(0, ctrl_pkg::UART_STATUS), "overrun cleared");

    // Interrupt with mask set and clear
    bus_write(sys_addr(ctrl_pkg::SYS_INT_MASK), 8'(1 << k));
    transfer(k, 8'($random(seed)), 1);
    idle(2);
    check({7'd0, int_irq}, {7'd0, expected_int()}, "int_o with mask set");
    read_check(sys_addr(ctrl_pkg::SYS_INT_STATUS), "int status set");
    read_check(chan_addr(k, ctrl_pkg::UART_DATA), "irq byte");
    idle(2);
    check({7'd0, int_irq}, {7'd0, expected_int()}, "int_o after data read");
    read_check(sys_addr(ctrl_pkg::SYS_INT_STATUS), "int status cleared");
    bus_write(sys_addr(ctrl_pkg::SYS_INT_MASK), 8'h00);
    transfer(k, 8'($random(seed)), 1);
    idle(2);
    check({7'd0, int_irq}, {7'd0, expected_int()}, "int_o with mask clear");
    read_check(sys_addr(ctrl_pkg::SYS_INT_STATUS), "raw status unmasked");
    read_check(chan_addr(k, ctrl_pkg::UART_DATA), "byte with mask clear");

    // Soft reset of one channel in the middle of a frame
    bus_write(chan_addr(k, ctrl_pkg::UART_BAUD_LO), 8'd37);
    bus_write(chan_addr(k, ctrl_pkg::UART_BAUD_HI), 8'd0);
    transfer(k, 8'($random(seed)), 1);
    bus_write(chan_addr(k, ctrl_pkg::UART_DATA), 8'h00);
    while (serial[k] !== 1'b0)              // Start bit on the line
        @(negedge clk);
    bus_write(sys_addr(ctrl_pkg::SYS_SOFT_RST), 8'(1 << k));
    idle(1);
    check(8'(serial[k]), 8'd1, "tx high in soft reset");
    for (int off = 0; off < 4; off++)
        read_check(chan_addr(k, 2'(off)), $sformatf("reg %0d in soft reset", off));
    read_check(sys_addr(ctrl_pkg::SYS_SOFT_RST), "soft reset bit");
    read_check(chan_addr(0, ctrl_pkg::UART_BAUD_LO), "other channel divisor kept");
    read_check(chan_addr(0, ctrl_pkg::UART_BAUD_HI), "other channel divisor hi kept");
    bus_write(sys_addr(ctrl_pkg::SYS_SOFT_RST), 8'h00);
    read_check(chan_addr(k, ctrl_pkg::UART_BAUD_LO), "divisor after release");

    idle(2);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, uut.u_control_board_assert.fail_cnt);
    if (errors == 0 && uut.u_control_board_assert.fail_cnt == 0)
        $display("Simulation completed successfully");
    else
        $display("Simulation failed");
    $finish;
end

endmodule

// ==== project.f ====
+incdir+.
ctrl_pkg.sv
lbs_decoder.sv
uart_channel.sv
sys_registers.sv
control_board.sv
control_board_assert.sv
tb_control_board.sv

// ==== Makefile ====
# Verilator build and run of the control board testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_control_board
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

SOURCES  = $(shell grep -v '^+' $(FILELIST)) ctrl_cfg.svh

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
